//--- sim.f
logic/emesh_pkg.sv
logic/node_pkg.sv
logic/mem_dp.sv
logic/fifo_sync.sv
logic/pkt_decode.sv
logic/reg_execute.sv
logic/resp_result.sv
logic/reg_node_top.sv
dv/tb_reg_node.sv

//--- dv/tb_reg_node.sv
// directed testbench; assumes NREGS 16 and a 64-byte aligned base, responses are checked in request order
`timescale 1ns/1ps

module tb_reg_node;

   localparam int          DEPTH     = 16;
   localparam logic [31:0] NODE_BASE = 32'h8000_0000;
   localparam int          NREGS     = 16;
   localparam logic [31:0] SEED      = 32'h9c1f_66cb;
   localparam int          N_WORD    = 8;  // write/read pairs
   localparam int          N_MASK    = 12; // masked write/read pairs
   localparam int          N_ADD     = 6;  // fetch-add/read pairs
   localparam int          N_MISS    = 6;  // bad write/read pairs
   localparam int          N_BP      = 30; // reads under back-pressure
   localparam int          TOTAL_REQS = 2*N_WORD + 2*N_MASK + 2*N_ADD + 3 + 2*N_MISS + N_BP;

   logic               clk;
   logic               nreset;
   logic               in_wr_en;
   emesh_pkg::packet_t in_packet;
   logic               in_full;
   logic               out_rd_en;
   emesh_pkg::packet_t out_packet;
   logic               out_empty;
   logic               miss;

   logic [31:0]        shadow [NREGS]; // reference register file
   emesh_pkg::packet_t expected_q [$]; // responses still owed
   int                 miss_cnt;       // pulses seen on miss
   int                 miss_exp;       // dropped requests sent

   reg_node_top #(
      .DEPTH     (DEPTH),
      .NODE_BASE (NODE_BASE),
      .NREGS     (NREGS)
   ) dut_i (
      .clk        (clk),
      .nreset     (nreset),
      .in_wr_en   (in_wr_en),
      .in_packet  (in_packet),
      .in_full    (in_full),
      .out_rd_en  (out_rd_en),
      .out_packet (out_packet),
      .out_empty  (out_empty),
      .miss       (miss)
   );

   //########################################
   // clock, watchdog, miss monitor
   //########################################
   initial
   begin
      clk = 1'b0;
      forever #2 clk = ~clk; // 4 ns period
   end

   initial
   begin
      repeat (TOTAL_REQS*40 + 200) @(posedge clk); // budget per request plus slack
      $display("timeout: tests did not finish in the allowed time");
      $display("Simulation FAILED");
      $fatal(1, "watchdog expired");
   end

   always @(negedge clk)
   begin
      if (nreset && miss)
         miss_cnt++; // miss is stable mid-cycle
   end

   //########################################
   // compare tasks
   //########################################
   task automatic compare_packet(input string name, input emesh_pkg::packet_t exp_pkt,
                                 input emesh_pkg::packet_t act_pkt);
      if (exp_pkt !== act_pkt)
      begin
         $display("Mismatch in %s: expected %h actual %h", name, exp_pkt, act_pkt);
         $display("Simulation FAILED");
         $fatal(1, "packet check failed");
      end
   endtask

   task automatic compare_flag(input string name, input logic exp_bit, input logic act_bit);
      if (exp_bit !== act_bit)
      begin
         $display("Mismatch in %s: expected %b actual %b", name, exp_bit, act_bit);
         $display("Simulation FAILED");
         $fatal(1, "flag check failed");
      end
   endtask

   //########################################
   // packet helpers and reference model
   //########################################
   function automatic emesh_pkg::packet_t make_pkt(input logic wr, input emesh_pkg::datamode_t dm,
                                                   input emesh_pkg::ctrlmode_t cm,
                                                   input logic [31:0] dst,
                                                   input logic [31:0] data,
                                                   input logic [31:0] src);
      emesh_pkg::packet_t p;
      p.write    = wr;
      p.datamode = dm;
      p.ctrlmode = cm;
      p.dstaddr  = dst;
      p.data     = data;
      p.srcaddr  = src;
      return p;
   endfunction

   function automatic logic [31:0] reg_addr(input int idx, input int off);
      return NODE_BASE + 32'(idx*4 + off); // word idx, byte off
   endfunction

   task automatic model_apply(input emesh_pkg::packet_t p);
      int          idx;
      int          lane;
      logic [31:0] old;
      idx = int'(p.dstaddr[5:2]);
      if (p.dstaddr[31:6] != NODE_BASE[31:6] || idx >= NREGS)
      begin
         miss_exp++; // dropped, no reply
      end
      else
      begin
         old = shadow[idx];
         if (p.write)
         begin
            if (p.datamode == emesh_pkg::DM_BYTE)
            begin
               lane = int'(p.dstaddr[1:0]);
               shadow[idx][8*lane +: 8] = p.data[7:0]; // low byte lands in addressed lane
            end
            else if (p.datamode == emesh_pkg::DM_HALF)
            begin
               lane = int'(p.dstaddr[1]);
               shadow[idx][16*lane +: 16] = p.data[15:0];
            end
            else
               shadow[idx] = p.data;
         end
         else
         begin
            if (p.ctrlmode == emesh_pkg::CTRL_FETCH_ADD)
               shadow[idx] = old + p.data; // wraps at 32 bits
            // reply swaps source and destination
            expected_q.push_back(make_pkt(1'b1, emesh_pkg::DM_WORD, '0, p.srcaddr, old,
                                          p.dstaddr));
         end
      end
   endtask

   //########################################
   // bus drivers
   //########################################
   task automatic send_request(input emesh_pkg::packet_t p);
      while (in_full)
      begin
         @(posedge clk);
         #0.5;
      end
      in_packet = p;
      in_wr_en  = 1'b1;
      @(posedge clk);
      #0.5;
      in_wr_en  = 1'b0;
      model_apply(p);
   endtask

   task automatic send_read(input int idx);
      send_request(make_pkt(1'b0, emesh_pkg::DM_WORD, '0, reg_addr(idx, 0), $urandom, $urandom));
   endtask

   task automatic drain_responses(input string name);
      emesh_pkg::packet_t exp_pkt;
      while (expected_q.size() > 0)
      begin
         out_rd_en = ~out_empty; // pop only what is there
         @(posedge clk);
         #0.5;
         if (out_rd_en)
         begin
            exp_pkt = expected_q.pop_front();
            compare_packet(name, exp_pkt, out_packet); // data one cycle after pop
         end
      end
      out_rd_en = 1'b0;
      repeat (8) @(posedge clk); // let the pipeline run dry
      #0.5;
      compare_flag({name, " no extra response"}, 1'b1, out_empty);
   endtask

   //########################################
   // directed tests
   //########################################
   task automatic test_word_rw();
      int idx;
      for (int i = 0; i < N_WORD; i++)
      begin
         idx = $urandom_range(NREGS-1, 0);
         send_request(make_pkt(1'b1, emesh_pkg::DM_WORD, '0, reg_addr(idx, 0), $urandom,
                               $urandom));
         send_read(idx);
      end
      drain_responses("test_word_rw");
   endtask

   task automatic test_masked_write();
      int                  idx;
      emesh_pkg::datamode_t dm;
      for (int i = 0; i < N_MASK; i++)
      begin
         idx = $urandom_range(NREGS-1, 0);
         dm  = ($urandom_range(1, 0) == 0) ? emesh_pkg::DM_BYTE : emesh_pkg::DM_HALF;
         // full random word, upper bits must be ignored
         send_request(make_pkt(1'b1, dm, '0, reg_addr(idx, $urandom_range(3, 0)), $urandom,
                               $urandom));
         send_read(idx);
      end
      drain_responses("test_masked_write");
   endtask

   task automatic test_fetch_add();
      int idx;
      // forced wrap past 2^32
      send_request(make_pkt(1'b1, emesh_pkg::DM_WORD, '0, reg_addr(3, 0), 32'hffff_fff0,
                            $urandom));
      send_request(make_pkt(1'b0, emesh_pkg::DM_WORD, emesh_pkg::CTRL_FETCH_ADD,
                            reg_addr(3, 0), 32'h20, $urandom));
      send_read(3);
      for (int i = 0; i < N_ADD; i++)
      begin
         idx = $urandom_range(NREGS-1, 0);
         send_request(make_pkt(1'b0, emesh_pkg::DM_WORD, emesh_pkg::CTRL_FETCH_ADD,
                               reg_addr(idx, 0), $urandom, $urandom));
         send_read(idx);
      end
      drain_responses("test_fetch_add");
   endtask

   task automatic test_miss();
      int          idx;
      logic [31:0] bad;
      for (int i = 0; i < N_MISS; i++)
      begin
         idx = $urandom_range(NREGS-1, 0);
         if (i % 2 == 0)
            bad = (NODE_BASE ^ 32'h4000_0000) + 32'(idx*4); // foreign node
         else
            bad = NODE_BASE + 32'h40 + 32'(idx*4);          // word 16 and up
         send_request(make_pkt(1'b1, emesh_pkg::DM_WORD, '0, bad, $urandom, $urandom));
         send_read(idx); // register must be untouched
      end
      drain_responses("test_miss");
      compare_flag($sformatf("test_miss pulse count %0d of %0d", miss_cnt, miss_exp), 1'b1,
                   miss_cnt == miss_exp);
   endtask

   task automatic test_backpressure();
      // output stays undrained, input FIFO fills behind it
      for (int i = 0; i < N_BP; i++)
         send_read($urandom_range(NREGS-1, 0));
      drain_responses("test_backpressure");
   endtask

   //########################################
   // main sequence
   //########################################
   initial
   begin
      void'($urandom(SEED));
      nreset    = 1'b0;
      in_wr_en  = 1'b0;
      in_packet = '0;
      out_rd_en = 1'b0;
      miss_cnt  = 0;
      miss_exp  = 0;
      for (int i = 0; i < NREGS; i++)
         shadow[i] = '0; // file clears on reset
      repeat (5) @(posedge clk);
      #0.5;
      nreset = 1'b1;
      compare_flag("reset out_empty", 1'b1, out_empty);
      compare_flag("reset in_full", 1'b0, in_full);
      compare_flag("reset miss", 1'b0, miss);
      test_word_rw();
      test_masked_write();
      test_fetch_add();
      test_miss();
      test_backpressure();
      $display("Simulation PASSED");
      $finish;
   end

endmodule

//--- logic/reg_node_top.sv
// mesh register node; user must not write while in_full is high and reads out_packet the cycle after out_rd_en
`timescale 1ns/1ps

module reg_node_top #(
   parameter int          DEPTH     = 16,            // both FIFOs
   parameter logic [31:0] NODE_BASE = 32'h8000_0000, // node address window
   parameter int          NREGS     = 16             // registers, max 16
) (
   input  logic               clk,
   input  logic               nreset,
   input  logic               in_wr_en,   // request push
   input  emesh_pkg::packet_t in_packet,  // request packet
   output logic               in_full,    // request FIFO full
   input  logic               out_rd_en,  // response pop
   output emesh_pkg::packet_t out_packet, // response, cycle after pop
   output logic               out_empty,  // no response waiting
   output logic               miss        // dropped request pulse
);

   emesh_pkg::packet_t   req_pkt;       // input FIFO dout
   logic                 req_empty;     // input FIFO level
   logic                 req_rd_en;     // decoder pop
   node_pkg::exec_req_t  exec_req;      // decode -> execute
   logic                 exec_valid;
   node_pkg::exec_resp_t exec_resp;     // execute -> result
   logic                 resp_valid;
   logic                 out_wr_en;     // result push
   emesh_pkg::packet_t   out_din;
   logic                 out_full;      // output FIFO full
   logic                 out_prog_full; // back-pressure level

   //########################################
   // request path
   //########################################
   fifo_sync #(
      .T         (emesh_pkg::packet_t),
      .DEPTH     (DEPTH),
      .PROG_FULL (DEPTH/2)
   ) in_fifo_i (
      .clk       (clk),
      .nreset    (nreset),
      .wr_en     (in_wr_en),
      .din       (in_packet),
      .rd_en     (req_rd_en),
      .dout      (req_pkt),
      .full      (in_full),
      .prog_full (),
      .empty     (req_empty),
      .count     ()
   );

   pkt_decode #(
      .NODE_BASE (NODE_BASE),
      .NREGS     (NREGS)
   ) pkt_decode_i (
      .clk           (clk),
      .nreset        (nreset),
      .fifo_empty    (req_empty),
      .fifo_rd_en    (req_rd_en),
      .fifo_dout     (req_pkt),
      .out_prog_full (out_prog_full),
      .exec_req      (exec_req),
      .exec_valid    (exec_valid),
      .miss          (miss)
   );

   reg_execute #(
      .NREGS (NREGS)
   ) reg_execute_i (
      .clk        (clk),
      .nreset     (nreset),
      .exec_req   (exec_req),
      .exec_valid (exec_valid),
      .exec_resp  (exec_resp),
      .resp_valid (resp_valid)
   );

   //########################################
   // response path
   //########################################
   resp_result resp_result_i (
      .clk        (clk),
      .nreset     (nreset),
      .exec_resp  (exec_resp),
      .resp_valid (resp_valid),
      .out_full   (out_full),
      .fifo_wr_en (out_wr_en),
      .fifo_din   (out_din)
   );

   fifo_sync #(
      .T         (emesh_pkg::packet_t),
      .DEPTH     (DEPTH),
      .PROG_FULL (DEPTH-3) // room for requests already popped
   ) out_fifo_i (
      .clk       (clk),
      .nreset    (nreset),
      .wr_en     (out_wr_en),
      .din       (out_din),
      .rd_en     (out_rd_en),
      .dout      (out_packet),
      .full      (out_full),
      .prog_full (out_prog_full),
      .empty     (out_empty),
      .count     ()
   );

endmodule

//--- logic/resp_result.sv
// response packer; relies on decoder back-pressure so the output FIFO always has room
`timescale 1ns/1ps

module resp_result (
   input  logic                 clk,
   input  logic                 nreset,
   input  node_pkg::exec_resp_t exec_resp,  // reply payload
   input  logic                 resp_valid, // one cycle strobe
   input  logic                 out_full,   // output FIFO level
   output logic                 fifo_wr_en, // push strobe
   output emesh_pkg::packet_t   fifo_din    // reply packet
);

   logic [15:0] resp_cnt; // responses pushed so far

   assign fifo_wr_en = resp_valid; // same cycle push

   always_comb
   begin
      fifo_din.write    = 1'b1;               // replies are writes
      fifo_din.datamode = emesh_pkg::DM_WORD;
      fifo_din.ctrlmode = '0;
      fifo_din.dstaddr  = exec_resp.dstaddr;
      fifo_din.data     = exec_resp.data;
      fifo_din.srcaddr  = exec_resp.srcaddr;
   end

   //########################################
   // response tally
   //########################################
   always_ff @(posedge clk or negedge nreset)
   begin
      if (!nreset)
      begin
         resp_cnt <= '0;
      end
      else if (fifo_wr_en)
      begin
         resp_cnt <= resp_cnt + 1'b1; // wraps, only for messages
      end
   end

   // prog_full margin upstream must cover the requests in flight
   a_no_drop: assert property (@(posedge clk) disable iff (!nreset)
      fifo_wr_en |-> !out_full)
      else $error("response %0d pushed into a full output FIFO", resp_cnt);

endmodule

//--- logic/reg_execute.sv
// register file of NREGS words cleared on reset; a response leaves one cycle after each read or fetch-and-add
`timescale 1ns/1ps

module reg_execute #(
   parameter int NREGS = 16 // registers present, max 16
) (
   input  logic                 clk,
   input  logic                 nreset,
   input  node_pkg::exec_req_t  exec_req,   // decoded operation
   input  logic                 exec_valid, // one cycle strobe
   output node_pkg::exec_resp_t exec_resp,  // reply payload
   output logic                 resp_valid  // one cycle strobe, no reply for writes
);

   logic [31:0] regs [NREGS]; // register file
   logic [31:0] cur;          // addressed register
   logic        wants_resp;   // read or fetch-and-add

   assign cur        = regs[exec_req.reg_idx];
   assign wants_resp = exec_valid & (exec_req.op != node_pkg::OP_WRITE);

   //########################################
   // register update
   //########################################
   always_ff @(posedge clk or negedge nreset)
   begin
      if (!nreset)
      begin
         for (int i = 0; i < NREGS; i++)
         begin
            regs[i] <= '0;
         end
         resp_valid <= 1'b0;
      end
      else
      begin
         resp_valid <= wants_resp;
         if (exec_valid)
         begin
            case (exec_req.op)
               node_pkg::OP_WRITE:
               begin
                  for (int b = 0; b < 4; b++)
                  begin
                     if (exec_req.be[b])
                     begin
                        regs[exec_req.reg_idx][8*b +: 8] <= exec_req.data[8*b +: 8];
                     end
                  end
               end
               node_pkg::OP_ADD:
               begin
                  regs[exec_req.reg_idx] <= cur + exec_req.data; // wraps mod 2^32
               end
               default:
               begin
                  // reads leave the file alone
               end
            endcase
         end
      end
   end

   //########################################
   // response payload
   //########################################
   always_ff @(posedge clk)
   begin
      if (wants_resp)
      begin
         exec_resp.data    <= cur;                 // old value for add
         exec_resp.dstaddr <= exec_req.reply_addr; // back to requester
         exec_resp.srcaddr <= exec_req.self_addr;
      end
   end

   // decoder filters out-of-range indices before they reach the file
   a_idx_range: assert property (@(posedge clk) disable iff (!nreset)
      exec_valid |-> ({1'b0, exec_req.reg_idx} < 5'(NREGS)));

endmodule

//--- logic/pkt_decode.sv
// request decoder; byte and half data sit in the low bits of the packet and are moved to the addressed lane here
`timescale 1ns/1ps

module pkt_decode #(
   parameter logic [31:0] NODE_BASE = 32'h8000_0000, // upper 26 bits compared
   parameter int          NREGS     = 16             // registers present, max 16
) (
   input  logic                clk,
   input  logic                nreset,
   input  logic                fifo_empty,    // input FIFO level
   output logic                fifo_rd_en,    // pop strobe
   input  emesh_pkg::packet_t  fifo_dout,     // popped packet, one cycle late
   input  logic                out_prog_full, // back-pressure from output FIFO
   output node_pkg::exec_req_t exec_req,      // decoded operation
   output logic                exec_valid,    // one cycle per hit
   output logic                miss           // one cycle per dropped request
);

   logic       pending;  // fifo_dout holds a fresh packet
   logic       base_hit; // address in this node
   logic       idx_hit;  // register exists
   logic [1:0] offset;   // byte offset in word
   logic [4:0] lane_sh;  // bit shift to the lane

   //########################################
   // pop control
   //########################################
   assign fifo_rd_en = ~fifo_empty & ~out_prog_full;

   always_ff @(posedge clk or negedge nreset)
   begin
      if (!nreset)
      begin
         pending <= 1'b0;
      end
      else
      begin
         pending <= fifo_rd_en; // fifo only pops when not empty
      end
   end

   //########################################
   // address check
   //########################################
   assign offset     = fifo_dout.dstaddr[1:0];
   assign base_hit   = (fifo_dout.dstaddr[31:6] == NODE_BASE[31:6]);
   assign idx_hit    = ({1'b0, fifo_dout.dstaddr[5:2]} < 5'(NREGS));
   assign exec_valid = pending & base_hit & idx_hit;
   assign miss       = pending & ~(base_hit & idx_hit);

   //########################################
   // operation fields
   //########################################
   always_comb
   begin
      case (fifo_dout.datamode)
         emesh_pkg::DM_BYTE:
         begin
            exec_req.be = 4'b0001 << offset;
            lane_sh     = {offset, 3'b000};
         end
         emesh_pkg::DM_HALF:
         begin
            exec_req.be = 4'b0011 << {offset[1], 1'b0}; // half-aligned
            lane_sh     = {offset[1], 4'b0000};
         end
         default:
         begin
            exec_req.be = 4'b1111; // word and the spare code
            lane_sh     = 5'd0;
         end
      endcase

      if (fifo_dout.write)
      begin
         exec_req.op = node_pkg::OP_WRITE;
      end
      else if (fifo_dout.ctrlmode == emesh_pkg::CTRL_FETCH_ADD)
      begin
         exec_req.op = node_pkg::OP_ADD;
      end
      else
      begin
         exec_req.op = node_pkg::OP_READ;
      end

      exec_req.reg_idx    = fifo_dout.dstaddr[5:2];
      exec_req.data       = fifo_dout.write ? (fifo_dout.data << lane_sh)
                                            : fifo_dout.data; // addend unshifted
      exec_req.reply_addr = fifo_dout.srcaddr; // answer the requester
      exec_req.self_addr  = fifo_dout.dstaddr;
   end

   // a pop only ever returns a slot that was written
   a_known_pop: assert property (@(posedge clk) disable iff (!nreset)
      pending |-> !$isunknown(fifo_dout));

endmodule

//--- logic/fifo_sync.sv
// sync FIFO holding DEPTH-1 entries; dout lags rd_en by one cycle, writes on full and reads on empty are dropped
`timescale 1ns/1ps

module fifo_sync #(
   parameter type T         = logic [31:0], // payload type
   parameter int  DEPTH     = 16,           // slots, one stays unused
   parameter int  PROG_FULL = DEPTH/2       // prog_full threshold
) (
   input  logic                     clk,
   input  logic                     nreset,
   input  logic                     wr_en,     // push strobe
   input  T                         din,       // push payload
   input  logic                     rd_en,     // pop strobe
   output T                         dout,      // popped payload, next cycle
   output logic                     full,      // count at DEPTH-1
   output logic                     prog_full, // count at or above threshold
   output logic                     empty,     // nothing stored
   output logic [$clog2(DEPTH)-1:0] count      // entries stored
);

   localparam int AW = $clog2(DEPTH);

   logic [AW-1:0] wr_ptr;     // next slot to write
   logic [AW-1:0] rd_ptr;     // next slot to read
   logic          fifo_write; // gated push
   logic          fifo_read;  // gated pop

   //########################################
   // status levels
   //########################################
   assign empty      = (count == '0);
   assign full       = (count == AW'(DEPTH-1));
   assign prog_full  = (count >= AW'(PROG_FULL));
   assign fifo_write = wr_en & ~full;  // drop on full
   assign fifo_read  = rd_en & ~empty; // drop on empty

   //########################################
   // pointers and count
   //########################################
   always_ff @(posedge clk or negedge nreset)
   begin
      if (!nreset)
      begin
         wr_ptr <= '0;
         rd_ptr <= '0;
         count  <= '0;
      end
      else
      begin
         if (fifo_write)
         begin
            wr_ptr <= (wr_ptr == AW'(DEPTH-1)) ? '0 : wr_ptr + 1'b1; // wrap for any depth
         end
         if (fifo_read)
         begin
            rd_ptr <= (rd_ptr == AW'(DEPTH-1)) ? '0 : rd_ptr + 1'b1;
         end
         if (fifo_write && !fifo_read)
         begin
            count <= count + 1'b1;
         end
         else if (fifo_read && !fifo_write)
         begin
            count <= count - 1'b1;
         end
      end
   end

   mem_dp #(
      .T     (T),
      .DEPTH (DEPTH)
   ) mem_i (
      .clk     (clk),
      .wr_en   (fifo_write),
      .wr_addr (wr_ptr),
      .wr_data (din),
      .rd_en   (fifo_read),
      .rd_addr (rd_ptr),
      .rd_data (dout)
   );

   // count tracks the pointer distance, so it stays at or below DEPTH-1
   a_count_bound: assert property (@(posedge clk) disable iff (!nreset)
      count == AW'((int'(wr_ptr) + DEPTH - int'(rd_ptr)) % DEPTH));

endmodule

//--- logic/mem_dp.sv
// register-array memory with one write and one registered read port on a single clock, no reset
`timescale 1ns/1ps

module mem_dp #(
   parameter type T     = logic [31:0], // payload type
   parameter int  DEPTH = 16            // number of entries
) (
   input  logic                     clk,
   input  logic                     wr_en,   // write strobe
   input  logic [$clog2(DEPTH)-1:0] wr_addr, // write index
   input  T                         wr_data, // write payload
   input  logic                     rd_en,   // read strobe
   input  logic [$clog2(DEPTH)-1:0] rd_addr, // read index
   output T                         rd_data  // valid the cycle after rd_en
);

   T mem [DEPTH]; // storage

   // write port
   always_ff @(posedge clk)
   begin
      if (wr_en)
      begin
         mem[wr_addr] <= wr_data;
      end
   end

   // read port, output holds between reads
   always_ff @(posedge clk)
   begin
      if (rd_en)
      begin
         rd_data <= mem[rd_addr];
      end
   end

endmodule

//--- logic/node_pkg.sv
// stage-to-stage records of the register node; reg_idx covers at most 16 registers
package node_pkg;

   // operation picked by the decoder
   typedef enum logic [1:0] {
      OP_WRITE = 2'd0, // masked store
      OP_READ  = 2'd1, // load, reply with value
      OP_ADD   = 2'd2  // fetch-and-add, reply with old value
   } op_t;

   // decode -> execute
   typedef struct packed {
      op_t         op;         // what to do
      logic [3:0]  reg_idx;    // word index inside the node
      logic [3:0]  be;         // byte enables for OP_WRITE
      logic [31:0] data;       // lane-aligned write data or addend
      logic [31:0] reply_addr; // request srcaddr, becomes reply dstaddr
      logic [31:0] self_addr;  // request dstaddr, becomes reply srcaddr
   } exec_req_t;

   // execute -> result
   typedef struct packed {
      logic [31:0] data;    // read value or old value
      logic [31:0] dstaddr; // back to requester
      logic [31:0] srcaddr; // the address that was hit
   } exec_resp_t;

endpackage

//--- logic/emesh_pkg.sv
// 104-bit mesh packet with 32-bit data only and fetch-and-add as the only ctrlmode in use
package emesh_pkg;

   //########################################
   // field types
   //########################################
   typedef logic [31:0] addr_t;     // byte address on the mesh
   typedef logic [31:0] data_t;     // payload word
   typedef logic [4:0]  ctrlmode_t; // atomic / control selector

   // transfer size, 2'b11 falls back to word
   typedef enum logic [1:0] {
      DM_BYTE = 2'b00, // 8 bit, data in bits 7:0
      DM_HALF = 2'b01, // 16 bit, data in bits 15:0
      DM_WORD = 2'b10  // 32 bit
   } datamode_t;

   //########################################
   // packet layout, msb first
   //########################################
   typedef struct packed {
      logic      write;    // 1 write, 0 read or atomic
      datamode_t datamode; // access size
      ctrlmode_t ctrlmode; // 0 plain, CTRL_FETCH_ADD atomic
      addr_t     dstaddr;  // target address
      data_t     data;     // write data or addend
      addr_t     srcaddr;  // requester address, reply goes here
   } packet_t;               // 1+2+5+32+32+32 = 104 bits

   // read-type request with this ctrlmode is a fetch-and-add
   localparam ctrlmode_t CTRL_FETCH_ADD = 5'h05;

endpackage
